//--- tb.f
source/rv_isa_pkg.sv
source/exe_pipe_pkg.sv
source/exe_in_fifo.sv
source/exe_credit_counter.sv
source/exe_flow_fsm.sv
source/pipeline_exe.sv
source/exe_stage_top.sv
verif/tb_exe_stage.sv

//--- run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_exe_stage -f tb.f -o tb_exe_stage_sim

# pass only when the pass line shows up in the output
./obj_dir/tb_exe_stage_sim | tee /dev/stderr | grep -F "STATUS: PASS" > /dev/null
echo "simulation passed"

//--- verif/tb_exe_stage.sv
`default_nettype none

module tb_exe_stage;

    import rv_isa_pkg::*;
    import exe_pipe_pkg::*;

    localparam int          NUM_VEC     = 18;
    localparam int          CYCLE_LIMIT = 20 * NUM_VEC + 200;
    localparam int unsigned SEED        = 32'hd1198bf7;

    logic     clk;
    logic     rst_n;
    logic     id_valid;
    id_exe_t  id_pkt;
    logic     id_credit;
    logic     mem_valid;
    exe_mem_t mem_pkt;
    logic     mem_credit = 1'b0;
    logic     flush;
    logic     halted;

    id_exe_t  in_pkts [$];         // decode side view of the table
    exe_mem_t exp_pkts [$];        // expected memory side view
    int       ret_delay [NUM_VEC]; // memory credit delay per packet
    int       exp_q [$];           // indices still to arrive
    int       ret_q [$];           // cycles when credits go back
    int       granted_cnt  = 0;    // decode credits seen
    int       spent_cnt    = 0;
    int       recv_cnt     = 0;
    int       returned_cnt = 0;
    int       cycle_cnt    = 0;
    int       grant_base;

    exe_stage_top i_exe_stage_top (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .id_valid_i   (id_valid),
        .id_pkt_i     (id_pkt),
        .id_credit_o  (id_credit),
        .mem_valid_o  (mem_valid),
        .mem_pkt_o    (mem_pkt),
        .mem_credit_i (mem_credit),
        .flush_i      (flush),
        .halted_o     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // imm, pc and rd come from the row number so every pass-through field differs
    function automatic void add_row(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
            dmem_type_e dt, result_src_e src, logic ill, logic [XLEN-1:0] res);
        id_exe_t  p;
        exe_mem_t e;
        int       n;
        n = in_pkts.size();
        p = '{op, a, b, XLEN'(n) << 12, 32'h1000 + XLEN'(4 * n + 4), dt, n[0],
              REG_IDX_W'(n), src, ill};
        e = '{res, p.extended_imm, p.pc_plus4, dt, n[0], REG_IDX_W'(n), src, ill};
        in_pkts.push_back(p);
        exp_pkts.push_back(e);
    endfunction

    // alu results worked out by hand
    task automatic load_table();
        add_row(ALU_ADD,  32'h1000,     32'h24,       DMEM_WORD,   SRC_MEM, 1'b0, 32'h1024);
        add_row(ALU_SUB,  32'h3,        32'h5,        DMEM_NONE,   SRC_ALU, 1'b0, 32'hfffffffe);
        add_row(ALU_AND,  32'hf0f0f0f0, 32'h0ff00ff0, DMEM_NONE,   SRC_ALU, 1'b0, 32'h00f000f0);
        add_row(ALU_OR,   32'hf0000000, 32'hf,        DMEM_HALF_U, SRC_MEM, 1'b0, 32'hf000000f);
        add_row(ALU_XOR,  32'haaaa5555, 32'hffff0000, DMEM_NONE,   SRC_IMM, 1'b0, 32'h55555555);
        add_row(ALU_SLL,  32'h1,        32'h24,       DMEM_NONE,   SRC_PC4, 1'b0, 32'h10); // shamt 4
        add_row(ALU_SRL,  32'h80000000, 32'h4,        DMEM_BYTE_U, SRC_MEM, 1'b0, 32'h08000000);
        add_row(ALU_SRA,  32'h80000000, 32'h4,        DMEM_NONE,   SRC_ALU, 1'b0, 32'hf8000000);
        add_row(ALU_SLT,  32'hffffffff, 32'h1,        DMEM_NONE,   SRC_ALU, 1'b0, 32'h1);
        add_row(ALU_SLTU, 32'hffffffff, 32'h1,        DMEM_BYTE,   SRC_MEM, 1'b0, 32'h0);
        add_row(ALU_ADD,  32'h1,        32'h1,        DMEM_NONE,   SRC_ALU, 1'b1, 32'h2);  // illegal
        // queued behind the illegal one and flushed later
        add_row(ALU_ADD,  32'h10,       32'h20,       DMEM_NONE,   SRC_ALU, 1'b0, 32'h30);
        add_row(ALU_SUB,  32'h100,      32'h1,        DMEM_NONE,   SRC_ALU, 1'b0, 32'hff);
        add_row(ALU_OR,   32'h3,        32'hc,        DMEM_NONE,   SRC_ALU, 1'b0, 32'hf);
        // after the flush
        add_row(ALU_ADD,  32'h7fffffff, 32'h1,        DMEM_HALF,   SRC_MEM, 1'b0, 32'h80000000);
        add_row(ALU_SRA,  32'h7ffffff0, 32'h21,       DMEM_NONE,   SRC_ALU, 1'b0, 32'h3ffffff8);
        add_row(ALU_SLT,  32'h1,        32'hffffffff, DMEM_NONE,   SRC_ALU, 1'b0, 32'h0);
        add_row(ALU_SLTU, 32'h1,        32'hffffffff, DMEM_NONE,   SRC_ALU, 1'b0, 32'h1);
    endtask

    // one packet per edge while decode holds a credit
    task automatic send_entry(input int idx, input bit expect_out);
        @(posedge clk);
        while (granted_cnt == spent_cnt) begin
            id_valid <= 1'b0;
            @(posedge clk);
        end
        id_valid  <= 1'b1;
        id_pkt    <= in_pkts[idx];
        spent_cnt = spent_cnt + 1;
        if (expect_out) exp_q.push_back(idx);
    endtask

    task automatic stop_decode();
        @(posedge clk);
        id_valid <= 1'b0;
    endtask

    // ============================================================
    // memory side model on pre-edge values
    // ============================================================
    always @(posedge clk) begin : mem_side
        int due;
        int idx;
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < CYCLE_LIMIT) else report_failure("timeout, run passed the cycle limit");
        if (rst_n) begin
            if (id_credit) granted_cnt <= granted_cnt + 1;
            if (mem_valid) begin
                assert (exp_q.size() > 0) else report_failure("unexpected packet on memory side");
                idx = exp_q.pop_front();
                assert (mem_pkt.alu_result == exp_pkts[idx].alu_result) else report_failure(
                    $sformatf("[FAIL] mem_pkt_o.alu_result entry %0d got %h expected %h",
                              idx, mem_pkt.alu_result, exp_pkts[idx].alu_result));
                assert (mem_pkt == exp_pkts[idx]) else report_failure(
                    $sformatf("[FAIL] mem_pkt_o entry %0d got %h expected %h",
                              idx, mem_pkt, exp_pkts[idx]));
                due = cycle_cnt + ret_delay[recv_cnt % NUM_VEC];
                if (ret_q.size() > 0 && due <= ret_q[$]) due = ret_q[$] + 1;  // one per cycle
                ret_q.push_back(due);
                recv_cnt = recv_cnt + 1;
            end
            if (ret_q.size() > 0 && ret_q[0] <= cycle_cnt) begin
                mem_credit   <= 1'b1;
                ret_q.delete(0);
                returned_cnt = returned_cnt + 1;
            end else begin
                mem_credit <= 1'b0;
            end
            assert (recv_cnt - returned_cnt <= MEM_CREDITS)
                else report_failure("more packets in flight to memory than its credits allow");
        end
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin : main_seq
        int i;
        void'($urandom(SEED));
        for (i = 0; i < NUM_VEC; i++) ret_delay[i] = $urandom_range(5, 0);
        load_table();
        rst_n    = 1'b0;
        id_valid = 1'b0;
        id_pkt   = '0;
        flush    = 1'b0;
        repeat (5) @(posedge clk);
        assert (!id_credit && !mem_valid && !halted) else report_failure($sformatf(
            "[FAIL] id_credit_o %h mem_valid_o %h halted_o %h in reset, expected 0",
            id_credit, mem_valid, halted));
        rst_n <= 1'b1;

        repeat (IN_DEPTH + 4) @(posedge clk);  // grant phase lasts IN_DEPTH cycles
        assert (granted_cnt == IN_DEPTH) else report_failure($sformatf(
            "[FAIL] id_credit_o pulses after reset %h expected %h", granted_cnt, IN_DEPTH));

        for (i = 0; i < 11; i++) send_entry(i, 1'b1);
        for (i = 11; i < 14; i++) send_entry(i, 1'b0);  // stuck behind the illegal entry
        stop_decode();
        while (!halted) @(posedge clk);
        repeat (10) @(posedge clk);
        assert (halted && exp_q.size() == 0)
            else report_failure("halt left early or packets before the illegal one missing");

        @(posedge clk);
        flush      <= 1'b1;
        grant_base = granted_cnt;
        spent_cnt  = granted_cnt;  // held credits are lost with the queue
        @(posedge clk);
        flush <= 1'b0;
        repeat (IN_DEPTH + 4) @(posedge clk);
        assert (!halted) else report_failure($sformatf("[FAIL] halted_o %h expected 0", halted));
        assert (granted_cnt - grant_base == IN_DEPTH) else report_failure($sformatf(
            "[FAIL] id_credit_o pulses after flush %h expected %h",
            granted_cnt - grant_base, IN_DEPTH));

        for (i = 14; i < NUM_VEC; i++) send_entry(i, 1'b1);
        stop_decode();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);  // room for stray flushed packets to show up

        // every pop hands exactly one credit back to decode
        if (granted_cnt - spent_cnt == IN_DEPTH) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure($sformatf("[FAIL] decode credits held at end %h expected %h",
                                     granted_cnt - spent_cnt, IN_DEPTH));
        end
    end

endmodule

`default_nettype wire

//--- source/exe_stage_top.sv
`default_nettype none

module exe_stage_top (
    input  wire                        clk,
    input  wire                        rst_n_i,
    // decode side
    input  wire                        id_valid_i,
    input  wire exe_pipe_pkg::id_exe_t id_pkt_i,
    output logic                       id_credit_o,
    // memory side
    output logic                       mem_valid_o,
    output exe_pipe_pkg::exe_mem_t     mem_pkt_o,
    input  wire                        mem_credit_i,
    // control
    input  wire                        flush_i,
    output logic                       halted_o
);

    // ============================================================
    // internal nets
    // ============================================================
    exe_pipe_pkg::id_exe_t head_pkt;  // oldest queued packet
    logic                  fifo_empty;
    logic                  credit_avail;
    logic                  issue;         // pop, spend and execute
    logic                  fifo_clear;

    exe_in_fifo i_exe_in_fifo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .push_i     (id_valid_i),
        .push_pkt_i (id_pkt_i),
        .pop_i      (issue),
        .clear_i    (fifo_clear),
        .head_pkt_o (head_pkt),
        .empty_o    (fifo_empty)
    );

    exe_credit_counter i_exe_credit_counter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .spend_i  (issue),
        .return_i (mem_credit_i),
        .avail_o  (credit_avail)
    );

    exe_flow_fsm i_exe_flow_fsm (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fifo_empty_i   (fifo_empty),
        .credit_avail_i (credit_avail),
        .head_illegal_i (head_pkt.instr_illegal),
        .flush_i        (flush_i),
        .pop_o          (issue),
        .clear_o        (fifo_clear),
        .id_credit_o    (id_credit_o),
        .halted_o       (halted_o)
    );

    pipeline_exe i_pipeline_exe (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue),
        .id_pkt_i    (head_pkt),
        .mem_valid_o (mem_valid_o),
        .mem_pkt_o   (mem_pkt_o)
    );

endmodule

`default_nettype wire

//--- source/pipeline_exe.sv
`default_nettype none

module pipeline_exe (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        issue_i,  // head popped this cycle
    input  wire exe_pipe_pkg::id_exe_t id_pkt_i,
    output logic                       mem_valid_o,
    output exe_pipe_pkg::exe_mem_t     mem_pkt_o
);

    import rv_isa_pkg::*;
    import exe_pipe_pkg::*;

    // ============================================================
    // alu
    // ============================================================
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;         // rs2[4:0]
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] alu_calc;
    exe_mem_t        exe_pkt_d;
    exe_mem_t        exe_pkt_q;
    logic            valid_q;

    assign op_a        = id_pkt_i.rs1;
    assign op_b        = id_pkt_i.rs2;
    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (id_pkt_i.alu_op)
            ALU_ADD:  alu_calc = op_a + op_b;
            ALU_SUB:  alu_calc = op_a - op_b;
            ALU_AND:  alu_calc = op_a & op_b;
            ALU_OR:   alu_calc = op_a | op_b;
            ALU_XOR:  alu_calc = op_a ^ op_b;
            ALU_SLL:  alu_calc = op_a << shamt;
            ALU_SRL:  alu_calc = op_a >> shamt;
            ALU_SRA:  alu_calc = $unsigned($signed(op_a) >>> shamt);  // sign fill
            ALU_SLT:  alu_calc = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: alu_calc = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  alu_calc = op_a + op_b;  // unknown op acts as add
        endcase
    end

    // ============================================================
    // execute -> memory register
    // ============================================================
    always_comb begin
        exe_pkt_d.alu_result    = alu_calc;
        exe_pkt_d.extended_imm  = id_pkt_i.extended_imm;  // lui
        exe_pkt_d.pc_plus4      = id_pkt_i.pc_plus4;      // jal
        exe_pkt_d.dmem_type     = id_pkt_i.dmem_type;
        exe_pkt_d.reg_write_en  = id_pkt_i.reg_write_en;
        exe_pkt_d.rd_idx        = id_pkt_i.rd_idx;
        exe_pkt_d.result_src    = id_pkt_i.result_src;    // wb mux picks later
        exe_pkt_d.instr_illegal = id_pkt_i.instr_illegal;
    end

    // payload held until next issue
    always_ff @(posedge clk) begin
        if (issue_i) begin
            exe_pkt_q <= exe_pkt_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i;  // one cycle per issued packet
        end
    end

    assign mem_valid_o = valid_q;
    assign mem_pkt_o   = exe_pkt_q;

endmodule

`default_nettype wire

//--- source/exe_flow_fsm.sv
`default_nettype none

module exe_flow_fsm (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  fifo_empty_i,
    input  wire  credit_avail_i,  // memory side has room
    input  wire  head_illegal_i,  // queue head flagged illegal
    input  wire  flush_i,
    output logic pop_o,
    output logic clear_o,
    output logic id_credit_o,
    output logic halted_o
);

    import exe_pipe_pkg::*;

    typedef enum logic [1:0] {
        ST_GRANT,  // hand out initial decode credits
        ST_RUN,
        ST_HALT    // illegal seen, wait for flush
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [IN_CNT_W-1:0] grant_cnt_q;  // credits granted so far
    logic                grant_last;
    logic                credit_q;     // registered credit pulse

    // ============================================================
    // issue and next state
    // ============================================================
    assign grant_last = (grant_cnt_q == IN_CNT_W'(IN_DEPTH - 1));
    assign pop_o      = (state_q == ST_RUN) && !fifo_empty_i && credit_avail_i;
    assign clear_o    = (state_q == ST_HALT) && flush_i;  // flush ignored elsewhere

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_GRANT: if (grant_last) state_d = ST_RUN;
            ST_RUN:   if (pop_o && head_illegal_i) state_d = ST_HALT;  // still delivered
            ST_HALT:  if (flush_i) state_d = ST_GRANT;
            default:  state_d = ST_GRANT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_GRANT;
            grant_cnt_q <= '0;
            credit_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == ST_GRANT) && !grant_last)
                grant_cnt_q <= grant_cnt_q + 1'b1;
            else
                grant_cnt_q <= '0;  // ready for next grant phase
            // one credit per grant cycle or per freed slot
            credit_q <= (state_q == ST_GRANT) || pop_o;
        end
    end

    assign id_credit_o = credit_q;
    assign halted_o    = (state_q == ST_HALT);

endmodule

`default_nettype wire

//--- source/exe_credit_counter.sv
`default_nettype none

module exe_credit_counter (
    input  wire  clk,
    input  wire  rst_n_i,
    input  wire  spend_i,   // packet issued toward memory
    input  wire  return_i,  // memory freed a slot
    output logic avail_o
);

    import exe_pipe_pkg::*;

    // ============================================================
    // credit count
    // ============================================================
    logic [MEM_CRED_W-1:0] credit_q;

    // starts full, memory buffer empty
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= MEM_CRED_W'(MEM_CREDITS);
        end else begin
            case ({spend_i, return_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;  // both cancel
            endcase
        end
    end

    // at least one slot free downstream
    assign avail_o = (credit_q != '0);

endmodule

`default_nettype wire

//--- source/exe_in_fifo.sv
`default_nettype none

module exe_in_fifo (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    push_i,      // decode packet valid
    input  wire exe_pipe_pkg::id_exe_t push_pkt_i,
    input  wire                    pop_i,       // issue
    input  wire                    clear_i,     // flush in halt
    output exe_pipe_pkg::id_exe_t  head_pkt_o,
    output logic                   empty_o
);

    import exe_pipe_pkg::*;

    // ============================================================
    // storage and pointers
    // ============================================================
    id_exe_t             mem_q [IN_DEPTH];  // payload only, no reset
    logic [IN_PTR_W-1:0] wr_ptr_q;
    logic [IN_PTR_W-1:0] rd_ptr_q;
    logic [IN_CNT_W-1:0] count_q;           // occupancy

    // write side, occupancy bounded by decode credits
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_pkt_i;
        end
    end

    // pointers wrap on the power of two depth
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin  // drop everything queued
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // idle or push+pop
            endcase
        end
    end

    assign head_pkt_o = mem_q[rd_ptr_q];  // oldest entry
    assign empty_o    = (count_q == '0);

endmodule

`default_nettype wire

//--- source/exe_pipe_pkg.sv
`default_nettype none

package exe_pipe_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int XLEN        = 32;  // data width
    localparam int REG_IDX_W   = 5;   // register file index
    localparam int IN_DEPTH    = 4;   // input queue slots, also decode credits
    localparam int MEM_CREDITS = 2;   // memory stage buffer slots

    localparam int IN_PTR_W   = $clog2(IN_DEPTH);       // queue pointer
    localparam int IN_CNT_W   = $clog2(IN_DEPTH + 1);   // queue occupancy
    localparam int MEM_CRED_W = $clog2(MEM_CREDITS + 1);

    // ============================================================
    // pipeline packets
    // ============================================================
    // decode -> execute
    typedef struct packed {
        rv_isa_pkg::alu_op_e     alu_op;
        logic [XLEN-1:0]         rs1;           // operand 1
        logic [XLEN-1:0]         rs2;           // operand 2
        logic [XLEN-1:0]         extended_imm;
        logic [XLEN-1:0]         pc_plus4;
        rv_isa_pkg::dmem_type_e  dmem_type;
        logic                    reg_write_en;
        logic [REG_IDX_W-1:0]    rd_idx;
        rv_isa_pkg::result_src_e result_src;
        logic                    instr_illegal;
    } id_exe_t;

    // execute -> memory
    typedef struct packed {
        logic [XLEN-1:0]         alu_result;
        logic [XLEN-1:0]         extended_imm;  // lui value
        logic [XLEN-1:0]         pc_plus4;      // jal link value
        rv_isa_pkg::dmem_type_e  dmem_type;
        logic                    reg_write_en;
        logic [REG_IDX_W-1:0]    rd_idx;
        rv_isa_pkg::result_src_e result_src;
        logic                    instr_illegal;
    } exe_mem_t;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // ============================================================
    // field widths
    // ============================================================
    localparam int ALU_OP_W     = 5;  // alu operation code
    localparam int RESULT_SRC_W = 4;  // one-hot writeback select
    localparam int DMEM_TYPE_W  = 3;  // load/store width and sign

    // ============================================================
    // alu operations
    // ============================================================
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,   // shift left logical
        ALU_SRL  = 5'd6,   // shift right logical
        ALU_SRA  = 5'd7,   // shift right arithmetic
        ALU_SLT  = 5'd8,   // signed compare
        ALU_SLTU = 5'd9    // unsigned compare
    } alu_op_e;

    // writeback select, one bit per mux input
    typedef enum logic [RESULT_SRC_W-1:0] {
        SRC_ALU = 4'b0001,
        SRC_MEM = 4'b0010,  // load data
        SRC_IMM = 4'b0100,  // lui
        SRC_PC4 = 4'b1000   // jal link value
    } result_src_e;

    // load/store access type
    typedef enum logic [DMEM_TYPE_W-1:0] {
        DMEM_NONE   = 3'd0,
        DMEM_BYTE   = 3'd1,
        DMEM_HALF   = 3'd2,
        DMEM_WORD   = 3'd3,
        DMEM_BYTE_U = 3'd4,  // lbu
        DMEM_HALF_U = 3'd5   // lhu
    } dmem_type_e;

endpackage

`default_nettype wire
